//--- verilog/tile_pkg.sv
`default_nettype none

package tile_pkg;

    // tile geometry
    localparam int TILE_DIM   = 16;
    localparam int COORD_W    = 4;
    localparam int GROUP_SIZE = 4;

    // wide enough for a signed x unsigned 8-bit product
    localparam int PRODUCT_W  = 17;

    typedef enum logic {
        sign_unsigned = 1'b0,
        sign_signed   = 1'b1
    } sign_mode_e;

    typedef enum logic {
        drain_idle = 1'b0,
        drain_busy = 1'b1
    } drain_state_e;

    // one nonzero weight and one nonzero activation
    typedef struct packed {
        logic [7:0]         weight;
        logic [1:0]         w_row;
        logic [1:0]         w_col;
        logic [7:0]         activation;
        logic [COORD_W-1:0] a_row;
        logic [COORD_W-1:0] a_col;
    } operand_beat_t;

    // beat 0 is the oldest
    typedef struct packed {
        operand_beat_t [GROUP_SIZE-1:0] beat;
    } operand_group_t;

    typedef struct packed {
        logic signed [PRODUCT_W-1:0] value;
        logic [COORD_W-1:0]          row;
        logic [COORD_W-1:0]          col;
    } product_t;

    // entry k is weight k mod 4 times activation k div 4
    typedef struct packed {
        product_t [GROUP_SIZE*GROUP_SIZE-1:0] entry;
    } product_group_t;

endpackage

`default_nettype wire

//--- verilog/operand_gather.sv
`default_nettype none
`timescale 1ns/100ps

module operand_gather (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  tile_pkg::operand_beat_t  in_beat,
    output logic                     group_valid,
    input  logic                     group_ready,
    output tile_pkg::operand_group_t group,
    output logic                     gathering
);

    localparam int CNT_W = $clog2(tile_pkg::GROUP_SIZE);

    logic [CNT_W-1:0] beat_cnt;
    logic             beat_accept;
    logic             last_beat;

    // stall only while a full group waits on the multiplier
    assign in_ready    = !group_valid || group_ready;
    assign beat_accept = in_valid && in_ready;
    assign last_beat   = beat_cnt == CNT_W'(tile_pkg::GROUP_SIZE - 1);
    assign gathering   = beat_cnt != '0;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            beat_cnt    <= '0;
            group_valid <= 1'b0;
        end else begin
            if (group_valid && group_ready) begin
                group_valid <= 1'b0;
            end
            if (beat_accept) begin
                // counter wraps to zero on the fourth beat
                beat_cnt <= beat_cnt + CNT_W'(1);
                if (last_beat) begin
                    group_valid <= 1'b1;
                end
            end
        end
    end

    // new beats enter at the top, so the oldest ends up in beat 0
    always_ff @(posedge clk) begin
        if (beat_accept) begin
            group.beat <= {in_beat, group.beat[tile_pkg::GROUP_SIZE-1:1]};
        end
    end

endmodule

`default_nettype wire

//--- verilog/cartesian_multiply.sv
`default_nettype none
`timescale 1ns/100ps

module cartesian_multiply (
    input  logic                     clk,
    input  logic                     reset_n,
    input  tile_pkg::sign_mode_e     weight_sign,
    input  tile_pkg::sign_mode_e     act_sign,
    input  logic                     group_valid,
    output logic                     group_ready,
    input  tile_pkg::operand_group_t group,
    output logic                     prod_valid,
    input  logic                     prod_ready,
    output tile_pkg::product_group_t products
);

    localparam int NUM_PROD = tile_pkg::GROUP_SIZE * tile_pkg::GROUP_SIZE;
    localparam int OPND_W   = 8;
    localparam int EXT_W    = OPND_W + 1;

    tile_pkg::product_group_t next_products;
    logic                     w_signed;
    logic                     a_signed;

    assign w_signed    = weight_sign == tile_pkg::sign_signed;
    assign a_signed    = act_sign == tile_pkg::sign_signed;
    assign group_ready = !prod_valid || prod_ready;

    for (genvar k = 0; k < NUM_PROD; k++) begin : g_prod
        tile_pkg::operand_beat_t    w_beat;
        tile_pkg::operand_beat_t    a_beat;
        logic signed [EXT_W-1:0]    w_ext;
        logic signed [EXT_W-1:0]    a_ext;
        logic signed [2*EXT_W-1:0]  full;

        assign w_beat = group.beat[k % tile_pkg::GROUP_SIZE];
        assign a_beat = group.beat[k / tile_pkg::GROUP_SIZE];

        // one extra bit turns either mode into a signed multiply
        assign w_ext = {w_signed && w_beat.weight[OPND_W-1], w_beat.weight};
        assign a_ext = {a_signed && a_beat.activation[OPND_W-1], a_beat.activation};
        assign full  = w_ext * a_ext;

        assign next_products.entry[k].value = full[tile_pkg::PRODUCT_W-1:0];
        // output coordinate wraps around the tile
        assign next_products.entry[k].row =
            a_beat.a_row + tile_pkg::COORD_W'(w_beat.w_row);
        assign next_products.entry[k].col =
            a_beat.a_col + tile_pkg::COORD_W'(w_beat.w_col);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_valid <= 1'b0;
        end else if (group_ready) begin
            prod_valid <= group_valid;
        end
    end

    // held while the drain is busy
    always_ff @(posedge clk) begin
        if (group_valid && group_ready) begin
            products <= next_products;
        end
    end

endmodule

`default_nettype wire

//--- verilog/scatter_accumulate.sv
`default_nettype none
`timescale 1ns/100ps

module scatter_accumulate #(
    parameter int ACC_WIDTH = 24
) (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        prod_valid,
    output logic                        prod_ready,
    input  tile_pkg::product_group_t    products,
    input  logic                        clear,
    input  logic [7:0]                  rd_addr,
    output logic signed [ACC_WIDTH-1:0] rd_data,
    output logic                        busy
);

    localparam int NUM_PROD = tile_pkg::GROUP_SIZE * tile_pkg::GROUP_SIZE;
    localparam int NUM_ACC  = tile_pkg::TILE_DIM * tile_pkg::TILE_DIM;
    localparam int IDX_W    = $clog2(NUM_PROD);

    tile_pkg::drain_state_e   state;
    logic [IDX_W-1:0]         drain_idx;
    tile_pkg::product_group_t held;
    tile_pkg::product_t       cur;
    logic [7:0]               wr_addr;
    logic signed [ACC_WIDTH-1:0] addend;
    logic signed [ACC_WIDTH-1:0] acc [NUM_ACC];

    assign prod_ready = state == tile_pkg::drain_idle;
    assign busy       = state == tile_pkg::drain_busy;

    // entry being drained this cycle
    assign cur     = held.entry[drain_idx];
    assign wr_addr = {cur.row, cur.col};
    assign addend  = ACC_WIDTH'(signed'(cur.value));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= tile_pkg::drain_idle;
            drain_idx <= '0;
        end else begin
            case (state)
                tile_pkg::drain_idle: begin
                    if (prod_valid) begin
                        state     <= tile_pkg::drain_busy;
                        drain_idx <= '0;
                    end
                end
                tile_pkg::drain_busy: begin
                    drain_idx <= drain_idx + IDX_W'(1);
                    // back to idle after the 16th update
                    if (drain_idx == IDX_W'(NUM_PROD - 1)) begin
                        state <= tile_pkg::drain_idle;
                    end
                end
                default: state <= tile_pkg::drain_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (prod_valid && prod_ready) begin
            held <= products;
        end
    end

    // one read-modify-write per cycle stands in for the crossbar
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < NUM_ACC; i++) begin
                acc[i] <= '0;
            end
        end else if (clear) begin
            for (int i = 0; i < NUM_ACC; i++) begin
                acc[i] <= '0;
            end
        end else if (busy) begin
            acc[wr_addr] <= acc[wr_addr] + addend;
        end
    end

    // registered read, row in the high nibble
    always_ff @(posedge clk) begin
        rd_data <= acc[rd_addr];
    end

endmodule

`default_nettype wire

//--- verilog/sparse_tile_top.sv
`default_nettype none
`timescale 1ns/100ps

module sparse_tile_top #(
    parameter int ACC_WIDTH = 24
) (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  tile_pkg::operand_beat_t     in_beat,
    input  tile_pkg::sign_mode_e        weight_sign,
    input  tile_pkg::sign_mode_e        act_sign,
    input  logic                        clear,
    input  logic [7:0]                  rd_addr,
    output logic signed [ACC_WIDTH-1:0] rd_data,
    output logic                        idle
);

    logic                     group_valid;
    logic                     group_ready;
    tile_pkg::operand_group_t group;
    logic                     gathering;
    logic                     prod_valid;
    logic                     prod_ready;
    tile_pkg::product_group_t products;
    logic                     busy;

    operand_gather operand_gather_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_beat     (in_beat),
        .group_valid (group_valid),
        .group_ready (group_ready),
        .group       (group),
        .gathering   (gathering)
    );

    cartesian_multiply cartesian_multiply_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .weight_sign (weight_sign),
        .act_sign    (act_sign),
        .group_valid (group_valid),
        .group_ready (group_ready),
        .group       (group),
        .prod_valid  (prod_valid),
        .prod_ready  (prod_ready),
        .products    (products)
    );

    scatter_accumulate #(
        .ACC_WIDTH (ACC_WIDTH)
    ) scatter_accumulate_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .prod_valid (prod_valid),
        .prod_ready (prod_ready),
        .products   (products),
        .clear      (clear),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .busy       (busy)
    );

    // nothing partial, held or draining anywhere in the pipe
    assign idle = !gathering && !group_valid && !prod_valid && !busy;

endmodule

`default_nettype wire

//--- verif/sparse_tile_props.sv
`default_nettype none
`timescale 1ns/100ps

module sparse_tile_props (
    input logic                     clk,
    input logic                     reset_n,
    input logic                     in_ready,
    input logic                     idle,
    input logic                     group_valid,
    input logic                     group_ready,
    input tile_pkg::operand_group_t group,
    input logic                     prod_valid,
    input logic                     prod_ready,
    input tile_pkg::product_group_t products
);

    // first edge out of reset
    reset_state: assert property (@(posedge clk) $rose(reset_n) |-> in_ready && idle)
        else $error("in_ready or idle low after reset");

    group_hold: assert property (@(posedge clk) disable iff (!reset_n)
        group_valid && !group_ready |=> group_valid && $stable(group))
        else $error("operand group changed before it was taken");

    prod_hold: assert property (@(posedge clk) disable iff (!reset_n)
        prod_valid && !prod_ready |=> prod_valid && $stable(products))
        else $error("product group changed before it was taken");

    // a drain holds off the next product group for 16 cycles
    drain_blocks: assert property (@(posedge clk) disable iff (!reset_n)
        prod_valid && prod_ready |=> !prod_ready ##15 !prod_ready ##1 prod_ready)
        else $error("prod_ready not low for exactly 16 cycles of a drain");

endmodule

`default_nettype wire

//--- verif/sparse_tile_tb.sv
`default_nettype none
`timescale 1ns/100ps

module sparse_tile_tb;

    localparam int ACC_WIDTH = 24;
    localparam int TIMEOUT   = 2000;

    logic                        clk;
    logic                        reset_n;
    logic                        in_valid;
    logic                        in_ready;
    tile_pkg::operand_beat_t     in_beat;
    tile_pkg::sign_mode_e        weight_sign;
    tile_pkg::sign_mode_e        act_sign;
    logic                        clear;
    logic [7:0]                  rd_addr;
    logic signed [ACC_WIDTH-1:0] rd_data;
    logic                        idle;
    // expected accumulator bank
    logic signed [ACC_WIDTH-1:0] model [16][16];
    logic [31:0]                 lfsr;
    int                          errors;
    int                          last_errors;
    int                          tests_run;
    logic                        timed_out;

    sparse_tile_top #(.ACC_WIDTH(ACC_WIDTH)) sparse_tile_top_i (.*);
    bind sparse_tile_top sparse_tile_props sparse_tile_props_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string what, input longint got, input longint exp);
        if (got != exp) begin
            errors++;
            $display("error at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic wait_high(input string name, input logic use_idle);
        int cnt;
        cnt = 0;
        while (!(use_idle ? idle : in_ready) && !timed_out) begin
            @(negedge clk);
            cnt++;
            if (cnt == TIMEOUT) begin
                errors++;
                timed_out = 1'b1;
                $display("gave up after %0d cycles waiting for %s to go high", TIMEOUT, name);
            end
        end
    endtask

    task automatic zero_model();
        foreach (model[r, c]) begin
            model[r][c] = '0;
        end
    endtask

    // all 16 weight x activation pairs of one group
    task automatic model_group(input tile_pkg::operand_group_t g);
        tile_pkg::operand_beat_t w;
        tile_pkg::operand_beat_t a;
        longint                  wv;
        longint                  av;
        int                      r;
        int                      c;
        for (int k = 0; k < 16; k++) begin
            w  = g.beat[k % 4];
            a  = g.beat[k / 4];
            wv = weight_sign == tile_pkg::sign_signed ? longint'($signed(w.weight))
                                                      : longint'(w.weight);
            av = act_sign == tile_pkg::sign_signed ? longint'($signed(a.activation))
                                                   : longint'(a.activation);
            // output coordinate wraps modulo the tile side
            r = (int'(a.a_row) + int'(w.w_row)) % tile_pkg::TILE_DIM;
            c = (int'(a.a_col) + int'(w.w_col)) % tile_pkg::TILE_DIM;
            model[r][c] += ACC_WIDTH'(wv * av);
        end
    endtask

    // in_valid stays high across back to back calls
    task automatic send_group(input tile_pkg::operand_group_t g);
        for (int i = 0; i < tile_pkg::GROUP_SIZE; i++) begin
            in_valid = 1'b1;
            in_beat  = g.beat[i];
            wait_high("in_ready", 1'b0);
            @(negedge clk);
        end
        in_valid = 1'b0;
        model_group(g);
    endtask

    // coordinates kept to 0..3 so outputs collide
    task automatic random_group(output tile_pkg::operand_group_t g);
        for (int i = 0; i < tile_pkg::GROUP_SIZE; i++) begin
            g.beat[i]            = 28'(random_bits($bits(tile_pkg::operand_beat_t)));
            g.beat[i].a_row[3:2] = 2'b00;
            g.beat[i].a_col[3:2] = 2'b00;
        end
    endtask

    task automatic compare_bank(input string what);
        for (int r = 0; r < 16; r++) begin
            for (int c = 0; c < 16; c++) begin
                rd_addr = {4'(r), 4'(c)};
                @(negedge clk);
                check_value($sformatf("%s acc[%0d][%0d]", what, r, c),
                            longint'(rd_data), longint'(model[r][c]));
            end
        end
    endtask

    task automatic clear_bank();
        wait_high("idle", 1'b1);
        clear = 1'b1;
        @(negedge clk);
        clear = 1'b0;
        zero_model();
    endtask

    task automatic finish_test(input string name);
        $display("%s: %s", name, errors == last_errors ? "ok" : "failed");
        last_errors = errors;
        tests_run++;
    endtask

    task automatic test_reset_state();
        check_value("idle after reset", longint'(idle), longint'(1));
        check_value("in_ready after reset", longint'(in_ready), longint'(1));
        compare_bank("after reset");
        finish_test("reset state");
    endtask

    task automatic test_unsigned_group();
        tile_pkg::operand_group_t g;
        weight_sign = tile_pkg::sign_unsigned;
        act_sign    = tile_pkg::sign_unsigned;
        g.beat[0]   = {8'd3, 2'd0, 2'd1, 8'd200, 4'd2, 4'd5};
        g.beat[1]   = {8'd255, 2'd3, 2'd3, 8'd255, 4'd15, 4'd14};
        g.beat[2]   = {8'd17, 2'd1, 2'd0, 8'd9, 4'd2, 4'd4};
        g.beat[3]   = {8'd128, 2'd2, 2'd2, 8'd1, 4'd7, 4'd0};
        send_group(g);
        wait_high("idle", 1'b1);
        compare_bank("unsigned group");
        finish_test("unsigned group");
    endtask

    task automatic test_signed_modes();
        tile_pkg::operand_group_t g;
        g.beat[0] = {8'hf0, 2'd1, 2'd3, 8'h80, 4'd14, 4'd15};
        g.beat[1] = {8'h81, 2'd0, 2'd2, 8'hff, 4'd1, 4'd0};
        g.beat[2] = {8'h7f, 2'd3, 2'd1, 8'hc3, 4'd13, 4'd2};
        g.beat[3] = {8'h80, 2'd2, 2'd0, 8'h05, 4'd0, 4'd15};
        for (int m = 0; m < 4; m++) begin
            clear_bank();
            weight_sign = tile_pkg::sign_mode_e'(m[1]);
            act_sign    = tile_pkg::sign_mode_e'(m[0]);
            send_group(g);
            wait_high("idle", 1'b1);
            compare_bank($sformatf("sign modes %0d", m));
        end
        finish_test("signed modes");
    endtask

    task automatic test_streaming();
        tile_pkg::operand_group_t g;
        weight_sign = tile_pkg::sign_signed;
        act_sign    = tile_pkg::sign_unsigned;
        for (int n = 0; n < 12; n++) begin
            random_group(g);
            send_group(g);
        end
        wait_high("idle", 1'b1);
        compare_bank("streaming");
        finish_test("streaming under back-pressure");
    endtask

    task automatic test_clear();
        tile_pkg::operand_group_t g;
        clear_bank();
        compare_bank("after clear");
        random_group(g);
        send_group(g);
        wait_high("idle", 1'b1);
        compare_bank("group after clear");
        finish_test("clear");
    endtask

    initial begin
        reset_n     = 1'b0;
        in_valid    = 1'b0;
        in_beat     = '0;
        weight_sign = tile_pkg::sign_unsigned;
        act_sign    = tile_pkg::sign_unsigned;
        clear       = 1'b0;
        rd_addr     = '0;
        lfsr        = 32'h8fc9_3aca;
        errors      = 0;
        last_errors = 0;
        tests_run   = 0;
        timed_out   = 1'b0;
        zero_model();
        repeat (8) @(negedge clk);
        reset_n = 1'b1;
        test_reset_state();
        test_unsigned_group();
        test_signed_modes();
        test_streaming();
        test_clear();
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
verilog/tile_pkg.sv
verilog/operand_gather.sv
verilog/cartesian_multiply.sv
verilog/scatter_accumulate.sv
verilog/sparse_tile_top.sv
verif/sparse_tile_props.sv
verif/sparse_tile_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run, then look for the pass line in the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module sparse_tile_tb -f verilog.f -o sparse_tile_sim
./obj_dir/sparse_tile_sim | tee sim.log
if grep -qx "TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
